//--- tb.f
source/mem_pkg.sv
source/line_arbiter.sv
source/burst_sequencer.sv
source/beat_collector.sv
source/mem_subsys.sv
tests/clk_gen.sv
tests/bmem_model.sv
tests/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_mem_subsys -f tb.f -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

//--- tests/tb_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam int ACK_TIMEOUT = 600;

    logic                 clk;
    logic                 rst;
    logic                 ic_req;
    logic [31:0]          ic_addr;
    logic                 ic_ack;
    line_rsp_t            ic_rsp;
    logic                 dc_req;
    line_req_t            dc_op;
    logic                 dc_ack;
    line_rsp_t            dc_rsp;
    mem_cmd_t             mem_cmd;
    logic                 mem_ready;
    logic                 mem_rvalid;
    logic [BEAT_BITS-1:0] mem_rdata;

    // stimulus table, one entry per line operation
    string                row_name[$];
    bit                   row_dc[$];
    bit                   row_wr[$];
    logic [31:0]          row_addr[$];
    logic [LINE_BITS-1:0] row_wline[$];
    logic [LINE_BITS-1:0] row_rline[$];
    bit                   row_pair[$];

    // expected memory contents per line
    logic [LINE_BITS-1:0] shadow [16];
    integer               seed = 99713;
    int                   cycle = 0;
    int                   error_count = 0;
    int                   ic_cycle;
    int                   dc_cycle;
    int                   solo_cycle;
    int                   idx;
    int                   waited;
    logic [31:0]          pick;

    clk_gen u_clk_gen (.clk(clk), .rst(rst));

    bmem_model u_bmem_model (
        .clk      (clk),
        .rst      (rst),
        .i_cmd    (mem_cmd),
        .o_ready  (mem_ready),
        .o_rvalid (mem_rvalid),
        .o_rdata  (mem_rdata)
    );

    mem_subsys i_mem_subsys (
        .clk          (clk),
        .rst          (rst),
        .i_ic_req     (ic_req),
        .i_ic_addr    (ic_addr),
        .o_ic_ack     (ic_ack),
        .o_ic_rsp     (ic_rsp),
        .i_dc_req     (dc_req),
        .i_dc_op      (dc_op),
        .o_dc_ack     (dc_ack),
        .o_dc_rsp     (dc_rsp),
        .o_mem_cmd    (mem_cmd),
        .i_mem_ready  (mem_ready),
        .i_mem_rvalid (mem_rvalid),
        .i_mem_rdata  (mem_rdata)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // preload contents, each beat carries its own line and beat number
    function automatic logic [LINE_BITS-1:0] fill_line(input logic [3:0] line_idx);
        logic [LINE_BITS-1:0] value;
        logic [5:0]           a;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            a = {line_idx, 2'(b)};
            value[b*BEAT_BITS +: BEAT_BITS] = {26'h2B51C3E, a, 26'h0D1E2F7, ~a};
        end
        return value;
    endfunction

    task automatic rand_line(output logic [LINE_BITS-1:0] value);
        for (int w = 0; w < LINE_BITS / 32; w++) begin
            value[w*32 +: 32] = $random(seed);
        end
    endtask

    // expected read line comes from the shadow copy in table order
    task automatic add_row(input string name, input bit dc, input bit wr,
                           input logic [31:0] addr, input bit pair);
        logic [LINE_BITS-1:0] wline;
        wline = '0;
        if (wr) begin
            rand_line(wline);
        end
        row_name.push_back(name);
        row_dc.push_back(dc);
        row_wr.push_back(wr);
        row_addr.push_back(addr);
        row_wline.push_back(wline);
        row_rline.push_back(shadow[addr[8:5]]);
        row_pair.push_back(pair);
        if (wr) begin
            shadow[addr[8:5]] = wline;
        end
    endtask

    task automatic check(input string name, input logic [LINE_BITS-1:0] expected,
                         input logic [LINE_BITS-1:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic wait_ack(input bit dc, input logic level, input string name);
        int count;
        count = 0;
        @(negedge clk);
        while ((dc ? dc_ack : ic_ack) !== level) begin
            count++;
            if (count > ACK_TIMEOUT) begin
                abort_run($sformatf("%s: ack did not go %s within %0d cycles",
                                    name, level ? "high" : "low", ACK_TIMEOUT));
            end
            @(negedge clk);
        end
    endtask

    // one full four-phase handshake on the row's client port
    task automatic run_row(input int r, output int ack_cycle);
        int hold;
        bit dc;
        dc = row_dc[r];
        @(posedge clk);
        if (dc) begin
            dc_req <= 1'b1;
            dc_op  <= {row_addr[r], row_wr[r], row_wline[r]};
        end else begin
            ic_req  <= 1'b1;
            ic_addr <= row_addr[r];
        end
        wait_ack(dc, 1'b1, row_name[r]);
        ack_cycle = cycle;
        if (!row_wr[r]) begin
            check(row_name[r], row_rline[r], dc ? dc_rsp.rdata.flat : ic_rsp.rdata.flat);
        end
        // client lingers on req, own ack stays and the other stays low
        hold = $random(seed) & 3;
        check({row_name[r], "_ack"}, 256'(2'b10),
              256'({dc ? dc_ack : ic_ack, dc ? ic_ack : dc_ack}));
        repeat (hold) begin
            @(negedge clk);
            check({row_name[r], "_hold"}, 256'(2'b10),
                  256'({dc ? dc_ack : ic_ack, dc ? ic_ack : dc_ack}));
        end
        @(posedge clk);
        if (dc) begin
            dc_req <= 1'b0;
        end else begin
            ic_req <= 1'b0;
        end
        wait_ack(dc, 1'b0, row_name[r]);
    endtask

    initial begin
        ic_req  = 1'b0;
        ic_addr = '0;
        dc_req  = 1'b0;
        dc_op   = '0;
        for (int i = 0; i < 16; i++) begin
            shadow[4'(i)] = fill_line(4'(i));
        end
        add_row("dc_wr_then_rd_w", 1'b1, 1'b1, 32'h0000_0040, 1'b0);
        add_row("dc_wr_then_rd_r", 1'b1, 1'b0, 32'h0000_0040, 1'b0);
        add_row("ic_rd_preloaded", 1'b0, 1'b0, 32'h0000_0100, 1'b0);
        add_row("both_rd_ic", 1'b0, 1'b0, 32'h0000_01E0, 1'b1);
        add_row("both_rd_dc", 1'b1, 1'b0, 32'h0000_0060, 1'b0);
        add_row("both_wr_ic", 1'b0, 1'b0, 32'h0000_0020, 1'b1);
        add_row("both_wr_dc", 1'b1, 1'b1, 32'h0000_0080, 1'b0);
        for (int i = 0; i < 16; i++) begin
            pick = $random(seed);
            add_row($sformatf("mixed_%0d", i), pick[4], pick[4] & pick[5],
                    {23'd0, pick[3:0], 5'd0}, 1'b0);
        end

        waited = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                abort_run("reset was never released");
            end
        end
        // nothing moves before the first request
        repeat (6) begin
            @(negedge clk);
            check("reset_quiet", '0, 256'({ic_ack, dc_ack, mem_cmd.read, mem_cmd.write}));
        end

        idx = 0;
        while (idx < row_name.size()) begin
            if (row_pair[idx]) begin
                fork
                    run_row(idx, ic_cycle);
                    run_row(idx + 1, dc_cycle);
                join
                check({row_name[idx], "_order"}, 256'(1), 256'(ic_cycle < dc_cycle));
                idx += 2;
            end else begin
                run_row(idx, solo_cycle);
                idx++;
            end
        end

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_mem_subsys

`default_nettype wire

//--- tests/bmem_model.sv
`timescale 1ns/100ps
`default_nettype none

module bmem_model
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  mem_cmd_t             i_cmd,
    output logic                 o_ready,
    output logic                 o_rvalid,
    output logic [BEAT_BITS-1:0] o_rdata
);

    // 16 lines, picked by address bits 8 to 5
    line_data_u           mem [16];
    integer               seed      = 99713;
    logic                 ready_q   = 1'b0;
    logic                 rvalid_q  = 1'b0;
    logic [BEAT_BITS-1:0] rdata_q   = '0;
    logic                 rd_active = 1'b0;
    logic [3:0]           rd_line   = '0;
    logic [1:0]           rd_beat   = '0;
    logic [1:0]           wr_beat   = '0;

    // every beat tagged with its own line and beat number
    initial begin
        for (int l = 0; l < 16; l++) begin
            for (int b = 0; b < BEATS_PER_LINE; b++) begin
                mem[4'(l)].beat[2'(b)] = {26'h2B51C3E, 4'(l), 2'(b), 26'h0D1E2F7, ~{4'(l), 2'(b)}};
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ready_q   <= 1'b0;
            rvalid_q  <= 1'b0;
            rd_active <= 1'b0;
            rd_beat   <= '0;
            wr_beat   <= '0;
        end else begin
            // ready drops about one cycle in four
            ready_q  <= ($random(seed) & 3) != 0;
            rvalid_q <= 1'b0;
            if (i_cmd.write && ready_q) begin
                mem[i_cmd.addr[8:5]].beat[wr_beat] <= i_cmd.wdata;
                wr_beat <= wr_beat + 2'd1;
            end
            if (i_cmd.read && ready_q) begin
                rd_active <= 1'b1;
                rd_line   <= i_cmd.addr[8:5];
                rd_beat   <= '0;
            end
            // beats return in order with random gaps
            if (rd_active && ($random(seed) & 1) == 1) begin
                rvalid_q <= 1'b1;
                rdata_q  <= mem[rd_line].beat[rd_beat];
                rd_beat  <= rd_beat + 2'd1;
                if (rd_beat == 2'd3) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    assign o_ready  = ready_q;
    assign o_rvalid = rvalid_q;
    assign o_rdata  = rdata_q;

endmodule : bmem_model

`default_nettype wire

//--- tests/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset over the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule : clk_gen

`default_nettype wire

//--- source/mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // instruction cache port
    input  logic                 i_ic_req,
    input  logic [31:0]          i_ic_addr,
    output logic                 o_ic_ack,
    output line_rsp_t            o_ic_rsp,

    // data cache port
    input  logic                 i_dc_req,
    input  line_req_t            i_dc_op,
    output logic                 o_dc_ack,
    output line_rsp_t            o_dc_rsp,

    // burst memory port
    output mem_cmd_t             o_mem_cmd,
    input  logic                 i_mem_ready,
    input  logic                 i_mem_rvalid,
    input  logic [BEAT_BITS-1:0] i_mem_rdata
);

    logic       op_start;
    line_req_t  op;
    logic       op_done;
    logic       read_pending;
    logic       line_valid;
    line_data_u line_rdata;

    line_arbiter u_line_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_ic_req     (i_ic_req),
        .i_ic_addr    (i_ic_addr),
        .o_ic_ack     (o_ic_ack),
        .o_ic_rsp     (o_ic_rsp),
        .i_dc_req     (i_dc_req),
        .i_dc_op      (i_dc_op),
        .o_dc_ack     (o_dc_ack),
        .o_dc_rsp     (o_dc_rsp),
        .o_op_start   (op_start),
        .o_op         (op),
        .i_op_done    (op_done),
        .i_line_rdata (line_rdata)
    );

    burst_sequencer u_burst_sequencer (
        .clk            (clk),
        .rst            (rst),
        .i_op_start     (op_start),
        .i_op           (op),
        .o_op_done      (op_done),
        .o_read_pending (read_pending),
        .o_mem_cmd      (o_mem_cmd),
        .i_mem_ready    (i_mem_ready),
        .i_line_valid   (line_valid)
    );

    beat_collector u_beat_collector (
        .clk            (clk),
        .rst            (rst),
        .i_read_pending (read_pending),
        .i_mem_rvalid   (i_mem_rvalid),
        .i_mem_rdata    (i_mem_rdata),
        .o_line_valid   (line_valid),
        .o_line_rdata   (line_rdata)
    );

endmodule : mem_subsys

`default_nettype wire

//--- source/beat_collector.sv
`timescale 1ns/100ps
`default_nettype none

module beat_collector
    import mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // read in flight, from the sequencer
    input  logic                 i_read_pending,

    // returned beats from memory
    input  logic                 i_mem_rvalid,
    input  logic [BEAT_BITS-1:0] i_mem_rdata,

    // assembled line
    output logic                 o_line_valid,
    output line_data_u           o_line_rdata
);

    logic [1:0] beat_cnt;
    line_data_u line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            o_line_valid <= 1'b0;
        end else begin
            o_line_valid <= 1'b0;
            if (!i_read_pending) begin
                beat_cnt <= '0;
            end else if (i_mem_rvalid) begin
                // wraps back to beat 0 after the last one
                beat_cnt <= beat_cnt + 2'd1;
                if (beat_cnt == 2'(BEATS_PER_LINE - 1)) begin
                    o_line_valid <= 1'b1;
                end
            end
        end
    end

    // beats arrive in order, each lands in its own slot
    always_ff @(posedge clk) begin
        if (i_read_pending && i_mem_rvalid) begin
            line_q.beat[beat_cnt] <= i_mem_rdata;
        end
    end

    assign o_line_rdata = line_q;

    // memory only returns data for a read we issued
    a_no_stray_rvalid: assert property (
        @(posedge clk) disable iff (rst)
        i_mem_rvalid |-> i_read_pending
    );

endmodule : beat_collector

`default_nettype wire

//--- source/burst_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module burst_sequencer
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // from the arbiter
    input  logic      i_op_start,
    input  line_req_t i_op,
    output logic      o_op_done,

    // to the beat collector
    output logic      o_read_pending,

    // burst memory command port
    output mem_cmd_t  o_mem_cmd,
    input  logic      i_mem_ready,

    // read line complete
    input  logic      i_line_valid
);

    line_req_t  op_q;
    logic       rd_q;
    logic       wr_q;
    logic       wr_done_q;
    logic [1:0] beat_cnt;
    logic       accept;

    // a command leaves on any cycle memory is ready for it
    assign accept = (rd_q | wr_q) & i_mem_ready;

    always_ff @(posedge clk) begin
        if (i_op_start) begin
            op_q <= i_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q           <= 1'b0;
            wr_q           <= 1'b0;
            wr_done_q      <= 1'b0;
            beat_cnt       <= '0;
            o_read_pending <= 1'b0;
        end else begin
            wr_done_q <= 1'b0;
            if (i_op_start) begin
                rd_q           <= !i_op.write;
                wr_q           <= i_op.write;
                beat_cnt       <= '0;
                o_read_pending <= !i_op.write;
            end else begin
                if (accept) begin
                    if (rd_q) begin
                        // single command, beats come back on rvalid
                        rd_q <= 1'b0;
                    end else if (beat_cnt == 2'(BEATS_PER_LINE - 1)) begin
                        wr_q      <= 1'b0;
                        wr_done_q <= 1'b1;
                    end else begin
                        beat_cnt <= beat_cnt + 2'd1;
                    end
                end
                if (i_line_valid) begin
                    o_read_pending <= 1'b0;
                end
            end
        end
    end

    // command is a view of held state, so it stays put while ready is low
    always_comb begin
        o_mem_cmd.addr  = op_q.addr;
        o_mem_cmd.read  = rd_q;
        o_mem_cmd.write = wr_q;
        o_mem_cmd.wdata = op_q.wdata.beat[beat_cnt];
    end

    // write finishes a cycle after the last beat, read with the line
    assign o_op_done = wr_done_q | i_line_valid;

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(o_mem_cmd.read && o_mem_cmd.write)
    );

endmodule : burst_sequencer

`default_nettype wire

//--- source/line_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module line_arbiter
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // instruction cache, read only
    input  logic        i_ic_req,
    input  logic [31:0] i_ic_addr,
    output logic        o_ic_ack,
    output line_rsp_t   o_ic_rsp,

    // data cache, reads and write-backs
    input  logic        i_dc_req,
    input  line_req_t   i_dc_op,
    output logic        o_dc_ack,
    output line_rsp_t   o_dc_rsp,

    // toward the burst sequencer
    output logic        o_op_start,
    output line_req_t   o_op,
    input  logic        i_op_done,
    input  line_data_u  i_line_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACK
    } state_t;

    state_t    state;
    logic      owner_dc;
    line_req_t ic_op;
    line_rsp_t rsp_q;
    logic      owner_req;

    // instruction side only ever reads
    always_comb begin
        ic_op.addr       = i_ic_addr;
        ic_op.write      = 1'b0;
        ic_op.wdata.flat = '0;
    end

    // req of whichever client holds the current operation
    assign owner_req = owner_dc ? i_dc_req : i_ic_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            owner_dc   <= 1'b0;
            o_op_start <= 1'b0;
            o_ic_ack   <= 1'b0;
            o_dc_ack   <= 1'b0;
        end else begin
            o_op_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // fixed priority, instruction side first
                    if (i_ic_req) begin
                        owner_dc   <= 1'b0;
                        o_op_start <= 1'b1;
                        state      <= ST_BUSY;
                    end else if (i_dc_req) begin
                        owner_dc   <= 1'b1;
                        o_op_start <= 1'b1;
                        state      <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (i_op_done) begin
                        state <= ST_ACK;
                        if (owner_dc) begin
                            o_dc_ack <= 1'b1;
                        end else begin
                            o_ic_ack <= 1'b1;
                        end
                    end
                end
                ST_ACK: begin
                    // hold ack until the owner lets go of req
                    if (!owner_req) begin
                        o_ic_ack <= 1'b0;
                        o_dc_ack <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // granted operation, kept for the whole transfer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (i_ic_req) begin
                o_op <= ic_op;
            end else if (i_dc_req) begin
                o_op <= i_dc_op;
            end
        end
    end

    // capture the read line as ack goes up
    always_ff @(posedge clk) begin
        if (state == ST_BUSY && i_op_done && !o_op.write) begin
            rsp_q.rdata <= i_line_rdata;
        end
    end

    // only the owner's ack is ever high, so one line register serves both
    assign o_ic_rsp = rsp_q;
    assign o_dc_rsp = rsp_q;

    a_one_ack: assert property (
        @(posedge clk) disable iff (rst)
        !(o_ic_ack && o_dc_ack)
    );

    // the caches must hand over line-aligned addresses
    a_line_aligned: assert property (
        @(posedge clk) disable iff (rst)
        o_op_start |-> (o_op.addr[4:0] == 5'd0)
    );

endmodule : line_arbiter

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // memory protocol geometry
    localparam int LINE_BITS      = 256;
    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = 4;

    // a line seen flat by the caches or as beats by the memory side
    // beat 0 sits in the low bits
    typedef union packed {
        logic [LINE_BITS-1:0]                     flat;
        logic [BEATS_PER_LINE-1:0][BEAT_BITS-1:0] beat;
    } line_data_u;

    // one line operation from a cache
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        line_data_u  wdata;
    } line_req_t;

    // line returned to the reading cache
    typedef struct packed {
        line_data_u rdata;
    } line_rsp_t;

    // one command on the burst memory port
    typedef struct packed {
        logic [31:0]          addr;
        logic                 read;
        logic                 write;
        logic [BEAT_BITS-1:0] wdata;
    } mem_cmd_t;

endpackage : mem_pkg

`default_nettype wire
